/* logic/memPkg.sv */
// Shared constants for the data-memory stage.
// Opcode values follow the MIPS I encoding of bits 31..26 of the instruction.
// defaultMemWords must stay a power of two, because the mapper slices the
// word index straight out of the rebased address.

package memPkg;

    // load opcodes
    localparam logic [5:0] opLb  = 6'h20;
    localparam logic [5:0] opLh  = 6'h21;
    localparam logic [5:0] opLw  = 6'h23;
    localparam logic [5:0] opLbu = 6'h24;
    localparam logic [5:0] opLhu = 6'h25;

    // store opcodes
    localparam logic [5:0] opSb  = 6'h28;
    localparam logic [5:0] opSh  = 6'h29;
    localparam logic [5:0] opSw  = 6'h2B;

    // size class of one access
    typedef enum logic [1:0] {
        unitWord = 2'd0,
        unitHalf = 2'd1,
        unitByte = 2'd2
    } accessUnit;

    // memory geometry defaults
    // 1024 words gives a 4 KiB data window
    localparam int          defaultMemWords = 1024;
    localparam logic [31:0] defaultDataBase = 32'h1001_0000;

endpackage

/* logic/memOpDecoder.sv */
// Opcode decoder for loads and stores.
// Only instr[31:26] is examined; function and register fields are ignored.
// Unknown opcodes decode as a non-writing word access with sign extension,
// so they read but never change memory.

`timescale 1ns/1ps

module memOpDecoder (
    input  logic [31:0]         instr,
    output logic                writeEn,
    output memPkg::accessUnit   unit,
    output logic                signExt
);

    logic [5:0] opcode;

    assign opcode = instr[31:26];

    // write enable for the three store forms
    always_comb begin
        case (opcode)
            memPkg::opSb,
            memPkg::opSh,
            memPkg::opSw: begin
                writeEn = 1'b1;
            end
            default: begin
                writeEn = 1'b0;
            end
        endcase
    end

    // size class, shared by loads and stores
    always_comb begin
        case (opcode)
            memPkg::opLb,
            memPkg::opLbu,
            memPkg::opSb: begin
                unit = memPkg::unitByte;
            end
            memPkg::opLh,
            memPkg::opLhu,
            memPkg::opSh: begin
                unit = memPkg::unitHalf;
            end
            memPkg::opLw,
            memPkg::opSw: begin
                unit = memPkg::unitWord;
            end
            default: begin
                unit = memPkg::unitWord;
            end
        endcase
    end

    // zero extension only for the unsigned loads
    always_comb begin
        case (opcode)
            memPkg::opLbu,
            memPkg::opLhu: begin
                signExt = 1'b0;
            end
            default: begin
                signExt = 1'b1;
            end
        endcase
    end

endmodule

/* logic/memAddrMapper.sv */
// Maps a byte address onto the data window.
// memWords must be a power of two and at most 2**30.
// One unsigned compare covers both ends of the window: addresses below
// dataBase wrap to large values after the subtraction and fail the test.
// No alignment check is made here.

`timescale 1ns/1ps

module memAddrMapper #(
    parameter int          memWords = 1024,
    parameter logic [31:0] dataBase = 32'h1001_0000
) (
    input  logic [31:0]                 addr,
    output logic [$clog2(memWords)-1:0] wordIndex,
    output logic [1:0]                  byteOffset,
    output logic                        halfOffset,
    output logic                        inRange
);

    localparam int indexBits = $clog2(memWords);

    // window size in bytes, one bit wider so a full 4 GiB window still fits
    localparam logic [32:0] windowBytes = 33'(memWords) << 2;

    logic [31:0] rebased;

    assign rebased = addr - dataBase;

    assign inRange = {1'b0, rebased} < windowBytes;

    // lane offsets inside the addressed word
    assign byteOffset = rebased[1:0];
    assign halfOffset = rebased[1];

    // word index sits just above the byte lanes
    assign wordIndex = rebased[indexBits+1:2];

endmodule

/* logic/dataMemory.sv */
// Word-wide data memory with byte and halfword lanes.
// Loads are combinational; stores land at the next rising edge of clk.
// Reset clears every word within a single cycle.
// Out-of-range loads return zero and out-of-range stores are dropped.
// Misaligned halfword and word stores are not supported.

`timescale 1ns/1ps

module dataMemory #(
    parameter int memWords = 1024
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        writeEn,
    input  memPkg::accessUnit           unit,
    input  logic                        signExt,
    input  logic [$clog2(memWords)-1:0] wordIndex,
    input  logic [1:0]                  byteOffset,
    input  logic                        halfOffset,
    input  logic                        inRange,
    input  logic [31:0]                 wData,
    output logic [31:0]                 rData
);

    logic [31:0] mem [memWords];

    logic [31:0] memWord;
    logic [7:0]  byteLane;
    logic [15:0] halfLane;
    logic [31:0] mergedWord;
    logic        memWrite;

    // addressed word reads as zero outside the window
    assign memWord = inRange ? mem[wordIndex] : 32'h0000_0000;

    // lane selection for loads and for the read half of a merge
    assign byteLane = memWord[byteOffset*8 +: 8];
    assign halfLane = memWord[halfOffset*16 +: 16];

    // load path
    always_comb begin
        case (unit)
            memPkg::unitByte: begin
                if (signExt) begin
                    rData = {{24{byteLane[7]}}, byteLane};
                end else begin
                    rData = {24'h00_0000, byteLane};
                end
            end
            memPkg::unitHalf: begin
                if (signExt) begin
                    rData = {{16{halfLane[15]}}, halfLane};
                end else begin
                    rData = {16'h0000, halfLane};
                end
            end
            default: begin
                rData = memWord;
            end
        endcase
    end

    // store path keeps the other lanes of the current word
    always_comb begin
        mergedWord = memWord;
        case (unit)
            memPkg::unitByte: begin
                mergedWord[byteOffset*8 +: 8] = wData[7:0];
            end
            memPkg::unitHalf: begin
                mergedWord[halfOffset*16 +: 16] = wData[15:0];
            end
            default: begin
                mergedWord = wData;
            end
        endcase
    end

    // stores outside the window are ignored
    assign memWrite = writeEn && inRange;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= 32'h0000_0000;
            end
        end else if (memWrite) begin
            mem[wordIndex] <= mergedWord;
        end
    end

    // halfword stores must sit on a halfword boundary
    halfStoreAligned: assert property (
        @(posedge clk) disable iff (reset)
        (memWrite && unit == memPkg::unitHalf) |-> !byteOffset[0]
    ) else $error("halfword store at odd byte offset %0d", byteOffset);

    // word stores must sit on a word boundary
    wordStoreAligned: assert property (
        @(posedge clk) disable iff (reset)
        (memWrite && unit == memPkg::unitWord) |-> byteOffset == 2'b00
    ) else $error("word store at byte offset %0d", byteOffset);

endmodule

/* logic/memStage.sv */
// Data-memory stage of a small 32-bit MIPS-style core.
// Loads answer combinationally in the cycle instr and addr are presented;
// stores update memory at the next rising edge of clk.
// memWords must be a power of two. No exceptions are raised for
// misaligned or unmapped accesses.

`timescale 1ns/1ps

module memStage #(
    parameter int          memWords = memPkg::defaultMemWords,
    parameter logic [31:0] dataBase = memPkg::defaultDataBase
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic [31:0] addr,
    input  logic [31:0] wData,
    output logic [31:0] rData
);

    // decoder results
    logic              writeEn;
    memPkg::accessUnit unit;
    logic              signExt;

    // mapper results
    logic [$clog2(memWords)-1:0] wordIndex;
    logic [1:0]                  byteOffset;
    logic                        halfOffset;
    logic                        inRange;

    memOpDecoder u_memOpDecoder (
        .instr   (instr),
        .writeEn (writeEn),
        .unit    (unit),
        .signExt (signExt)
    );

    memAddrMapper #(
        .memWords (memWords),
        .dataBase (dataBase)
    ) u_memAddrMapper (
        .addr       (addr),
        .wordIndex  (wordIndex),
        .byteOffset (byteOffset),
        .halfOffset (halfOffset),
        .inRange    (inRange)
    );

    dataMemory #(
        .memWords (memWords)
    ) u_dataMemory (
        .clk        (clk),
        .reset      (reset),
        .writeEn    (writeEn),
        .unit       (unit),
        .signExt    (signExt),
        .wordIndex  (wordIndex),
        .byteOffset (byteOffset),
        .halfOffset (halfOffset),
        .inRange    (inRange),
        .wData      (wData),
        .rData      (rData)
    );

endmodule

/* tests/memStageTb.sv */
// Testbench for the data-memory stage, run with the package default geometry.
// Loads are checked by a concurrent assertion at the falling edge, against a
// model array that follows the lane rules of the stage.
// Only aligned halfword and word stores are issued.

`timescale 1ns/1ps

module memStageTb;

    localparam int          memWords    = memPkg::defaultMemWords;
    localparam logic [31:0] dataBase    = memPkg::defaultDataBase;
    localparam int          indexBits   = $clog2(memWords);
    localparam logic [31:0] windowBytes = 32'(memWords * 4);
    localparam int          clkPeriod   = 8;
    localparam int          resetCycles = 16;

    // cycles per test, each with one closing idle cycle
    localparam int test1Cycles  = 32 + 1;
    localparam int test2Cycles  = 64 * 2 + 1;
    localparam int test3Cycles  = 16 * 6 + 1;
    localparam int test4Cycles  = 16 * 13 + 1;
    localparam int test5Cycles  = 2 + 32 + 32 + memWords + 1;
    localparam int test6Cycles  = 32 + memWords + 1;
    localparam int marginCycles = 100;
    localparam int totalCycles  = resetCycles + test1Cycles + test2Cycles + test3Cycles
                                + test4Cycles + test5Cycles + test6Cycles;

    localparam logic [5:0] loadOps [5] = '{
        memPkg::opLb, memPkg::opLh, memPkg::opLw, memPkg::opLbu, memPkg::opLhu
    };
    localparam logic [5:0] storeOps [3] = '{memPkg::opSb, memPkg::opSh, memPkg::opSw};

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] addr;
    logic [31:0] wData;
    logic [31:0] rData;

    // reference copy of the data window
    logic [31:0] model [memWords];

    logic [31:0] lfsrState = 32'h43e8a5df;
    logic        checkLoad;
    logic [31:0] expData;
    int          errorCount = 0;
    int          checkCount = 0;
    int          testErrors = 0;

    memStage u_memStage (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .addr  (addr),
        .wData (wData),
        .rData (rData)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #((totalCycles + marginCycles) * clkPeriod);
        $display("timeout: the run did not finish within %0d clock cycles",
                 totalCycles + marginCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // inputs change 1 ns after the rising edge, so the falling edge sees settled data
    loadMatches: assert property (
        @(negedge clk) disable iff (reset)
        checkLoad |-> rData == expData
    ) else begin
        errorCount++;
        $display("ERR rData expected %08h actual %08h at %0t",
                 $sampled(expData), $sampled(rData), $time);
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        logic        outBit;
        value = 32'h0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit) begin
                lfsrState = lfsrState ^ 32'hA300_0000;
            end
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    function automatic bit isLoad(input logic [5:0] op);
        return op == memPkg::opLb || op == memPkg::opLh || op == memPkg::opLw
            || op == memPkg::opLbu || op == memPkg::opLhu;
    endfunction

    function automatic bit isStore(input logic [5:0] op);
        return op == memPkg::opSb || op == memPkg::opSh || op == memPkg::opSw;
    endfunction

    function automatic logic [31:0] wordAddr(input int index, input int offset);
        return dataBase + 32'(index * 4 + offset);
    endfunction

    // word-aligned address just outside either end of the window
    function automatic logic [31:0] outsideAddr();
        logic        below;
        logic [31:0] step;
        below = randBits(1);
        step = 4 * randBits(12);
        if (below) begin
            return dataBase - 32'd4 - step;
        end
        return dataBase + windowBytes + step;
    endfunction

    function automatic logic [31:0] expectedLoad(input logic [5:0] op, input logic [31:0] a);
        logic [31:0] offset;
        logic [31:0] word;
        logic [31:0] lane;
        offset = a - dataBase;
        if (offset >= windowBytes) begin
            return 32'h0;
        end
        word = model[offset >> 2];
        if (op == memPkg::opLb || op == memPkg::opLbu) begin
            lane = (word >> (8 * offset[1:0])) & 32'h0000_00FF;
            if (op == memPkg::opLb && lane[7]) begin
                lane = lane | 32'hFFFF_FF00;
            end
        end else if (op == memPkg::opLh || op == memPkg::opLhu) begin
            lane = (word >> (16 * offset[1])) & 32'h0000_FFFF;
            if (op == memPkg::opLh && lane[15]) begin
                lane = lane | 32'hFFFF_0000;
            end
        end else begin
            lane = word;
        end
        return lane;
    endfunction

    // apply a store to the model, dropped outside the window
    function automatic void updateModel(input logic [5:0] op, input logic [31:0] a,
                                        input logic [31:0] d);
        logic [31:0] offset;
        logic [31:0] word;
        logic [31:0] mask;
        int          shift;
        offset = a - dataBase;
        if (offset < windowBytes) begin
            word = model[offset >> 2];
            if (op == memPkg::opSb) begin
                shift = 8 * offset[1:0];
                mask = 32'h0000_00FF << shift;
                word = (word & ~mask) | ((d & 32'h0000_00FF) << shift);
            end else if (op == memPkg::opSh) begin
                shift = 16 * offset[1];
                mask = 32'h0000_FFFF << shift;
                word = (word & ~mask) | ((d & 32'h0000_FFFF) << shift);
            end else begin
                word = d;
            end
            model[offset >> 2] = word;
        end
    endfunction

    // one access per cycle
    task automatic access(input logic [5:0] op, input logic [31:0] a, input logic [31:0] d);
        logic [25:0] lowBits;
        lowBits = 26'(randBits(26));
        @(posedge clk);
        #1;
        instr = {op, lowBits};
        addr = a;
        wData = d;
        if (isLoad(op)) begin
            expData = expectedLoad(op, a);
            checkLoad = 1'b1;
            checkCount++;
        end else begin
            checkLoad = 1'b0;
            if (isStore(op)) begin
                updateModel(op, a, d);
            end
        end
    endtask

    task automatic sweepWords();
        for (int i = 0; i < memWords; i++) begin
            access(memPkg::opLw, wordAddr(i, 0), 32'h0);
        end
    endtask

    // idle cycle lets the last load be checked before the summary line
    task automatic endTest(input int num, input string name);
        @(posedge clk);
        #1;
        instr = 32'h0;
        addr = 32'h0;
        wData = 32'h0;
        checkLoad = 1'b0;
        $display("test %0d %s: %0d mismatches", num, name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    initial begin
        int          idx;
        int          lane;
        logic [31:0] data;
        logic [31:0] a;
        logic [5:0]  op;
        int          indexQ[$];

        reset = 1'b1;
        instr = 32'h0;
        addr = 32'h0;
        wData = 32'h0;
        checkLoad = 1'b0;
        expData = 32'h0;
        for (int i = 0; i < memWords; i++) begin
            model[i] = 32'h0;
        end
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (32) begin
            idx = randBits(indexBits);
            access(memPkg::opLw, wordAddr(idx, 0), 32'h0);
        end
        endTest(1, "loads after reset");

        repeat (64) begin
            idx = randBits(indexBits);
            data = randBits(32);
            indexQ.push_back(idx);
            access(memPkg::opSw, wordAddr(idx, 0), data);
        end
        foreach (indexQ[i]) begin
            access(memPkg::opLw, wordAddr(indexQ[i], 0), 32'h0);
        end
        endTest(2, "word store and load");

        repeat (16) begin
            idx = randBits(indexBits);
            data = randBits(32);
            access(memPkg::opSw, wordAddr(idx, 0), data);
            repeat (4) begin
                data = randBits(32);
                if (randBits(1)) begin
                    lane = randBits(2);
                    access(memPkg::opSb, wordAddr(idx, lane), data);
                end else begin
                    lane = randBits(1);
                    access(memPkg::opSh, wordAddr(idx, lane * 2), data);
                end
            end
            access(memPkg::opLw, wordAddr(idx, 0), 32'h0);
        end
        endTest(3, "lane merge");

        // top bit of each byte follows the iteration count
        for (int iter = 0; iter < 16; iter++) begin
            idx = randBits(indexBits);
            data = randBits(32);
            for (int k = 0; k < 4; k++) begin
                data[8 * k + 7] = iter[k];
            end
            access(memPkg::opSw, wordAddr(idx, 0), data);
            for (int k = 0; k < 4; k++) begin
                access(memPkg::opLb, wordAddr(idx, k), 32'h0);
                access(memPkg::opLbu, wordAddr(idx, k), 32'h0);
            end
            for (int k = 0; k < 2; k++) begin
                access(memPkg::opLh, wordAddr(idx, k * 2), 32'h0);
                access(memPkg::opLhu, wordAddr(idx, k * 2), 32'h0);
            end
        end
        endTest(4, "load extension");

        // exact window edges first
        access(memPkg::opLw, dataBase - 32'd4, 32'h0);
        access(memPkg::opLw, dataBase + windowBytes, 32'h0);
        repeat (32) begin
            a = outsideAddr();
            op = loadOps[randBits(3) % 5];
            access(op, a, 32'h0);
        end
        repeat (32) begin
            a = outsideAddr();
            op = storeOps[randBits(2) % 3];
            data = randBits(32);
            access(op, a, data);
        end
        sweepWords();
        endTest(5, "out of range");

        repeat (32) begin
            do begin
                op = 6'(randBits(6));
            end while (isLoad(op) || isStore(op));
            idx = randBits(indexBits);
            lane = randBits(2);
            data = randBits(32);
            access(op, wordAddr(idx, lane), data);
        end
        sweepWords();
        endTest(6, "non-memory opcodes");

        $display("%0d loads checked, %0d mismatches", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* memStage.f */
logic/memPkg.sv
logic/memOpDecoder.sv
logic/memAddrMapper.sv
logic/dataMemory.sv
logic/memStage.sv
tests/memStageTb.sv
